// ==== filelist.f ====
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/imem_loader.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/cpu_top.sv
test/cpu_checker.sv
test/tb_cpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_cpu -f filelist.f -o tb_cpu_sim

output="$(./obj_dir/tb_cpu_sim)"
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// ==== source/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and register file sizes
`define CPU_XLEN          32
`define CPU_REG_COUNT     32

// Instruction memory, word addressed
`define CPU_IMEM_DEPTH    64
`define CPU_IMEM_AW       6

// JAL offset that marks the halt instruction (jump to itself)
`define CPU_HALT_JAL_IMM  32'h0000_0000

`endif

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_top import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      run,
    input  load_req_t load_req,
    input  logic      load_req_valid,
    output logic      load_ack,
    output retire_t   retire,
    output logic      halted,
    output word_t     rega0
);

    logic [`CPU_IMEM_AW-1:0] imem_addr;
    word_t                   imem_data;
    fetch_decode_t           fd_reg;
    decode_execute_t         de_reg;
    retire_t                 ew_reg;
    reg_addr_t               rs1_addr;
    reg_addr_t               rs2_addr;
    word_t                   rs1_data;
    word_t                   rs2_data;
    logic                    redirect_valid;
    word_t                   redirect_pc;

    ////////////////////
    // Program load and fetch

    imem_loader loader0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .run            (run),
        .load_req       (load_req),
        .load_req_valid (load_req_valid),
        .load_ack       (load_ack),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data)
    );

    fetch_stage fetch0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .run            (run),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .halted         (halted),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .fd_reg         (fd_reg)
    );

    ////////////////////
    // Decode and registers

    decode_stage decode0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .run            (run),
        .fd_reg         (fd_reg),
        .redirect_valid (redirect_valid),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .de_reg         (de_reg)
    );

    register_file regfile0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (ew_reg),
        .rega0    (rega0)
    );

    ////////////////////
    // Execute and retire

    execute_stage execute0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .run            (run),
        .de_reg         (de_reg),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .halted         (halted),
        .ew_reg         (ew_reg)
    );

    assign retire = ew_reg;

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            run,
    input  fetch_decode_t   fd_reg,
    input  logic            redirect_valid,
    output reg_addr_t       rs1_addr,
    output reg_addr_t       rs2_addr,
    input  word_t           rs1_data,
    input  word_t           rs2_data,
    output decode_execute_t de_reg
);

    instr_fields_t   fields;
    word_t           instr;
    word_t           imm_i;
    word_t           imm_b;
    word_t           imm_u;
    word_t           imm_j;
    decode_execute_t dec;

    assign instr  = fd_reg.instr;
    assign fields = instr_fields_t'(instr);

    assign rs1_addr = fields.rs1;
    assign rs2_addr = fields.rs2;

    ////////////////////
    // Immediates

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    ////////////////////
    // Control decode

    always_comb begin
        dec           = '0;
        dec.valid     = fd_reg.valid;
        dec.pc        = fd_reg.pc;
        dec.rs1       = fields.rs1;
        dec.rs2       = fields.rs2;
        dec.rs1_data  = rs1_data;
        dec.rs2_data  = rs2_data;
        dec.rd        = fields.rd;
        dec.alu_op    = alu_add;

        case (fields.opcode)
            op_reg: begin
                dec.reg_write = 1'b1;
                case (fields.funct3)
                    F3_ADD_SUB: dec.alu_op = fields.funct7[5] ? alu_sub : alu_add;
                    F3_SLT:     dec.alu_op = alu_slt;
                    F3_XOR:     dec.alu_op = alu_xor;
                    F3_OR:      dec.alu_op = alu_or;
                    F3_AND:     dec.alu_op = alu_and;
                    default:    dec.valid  = 1'b0;
                endcase
            end
            op_imm: begin
                // ADDI only
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.imm       = imm_i;
                if (fields.funct3 != F3_ADD_SUB) dec.valid = 1'b0;
            end
            op_lui: begin
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.imm       = imm_u;
                dec.alu_op    = alu_pass_b;
            end
            op_branch: begin
                dec.is_branch = 1'b1;
                dec.imm       = imm_b;
                dec.branch_ne = (fields.funct3 == F3_BNE);
                if (fields.funct3 != F3_BEQ && fields.funct3 != F3_BNE) dec.valid = 1'b0;
            end
            op_jal: begin
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
                dec.imm       = imm_j;
            end
            // Anything else becomes a bubble
            default: dec.valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de_reg <= '0;
        end else if (!run || redirect_valid) begin
            de_reg <= '0;
        end else begin
            de_reg <= dec;
        end
    end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            run,
    input  decode_execute_t de_reg,
    output logic            redirect_valid,
    output word_t           redirect_pc,
    output logic            halted,
    output retire_t         ew_reg
);

    word_t op_a;
    word_t op_b;
    word_t fwd_rs2;
    word_t alu_result;
    word_t result;
    logic  operands_eq;
    logic  branch_taken;
    logic  is_halt;

    ////////////////////
    // Forwarding from writeback

    always_comb begin
        op_a    = de_reg.rs1_data;
        fwd_rs2 = de_reg.rs2_data;
        if (ew_reg.valid && ew_reg.rd != '0 && ew_reg.rd == de_reg.rs1) op_a = ew_reg.data;
        if (ew_reg.valid && ew_reg.rd != '0 && ew_reg.rd == de_reg.rs2) fwd_rs2 = ew_reg.data;
    end

    assign op_b = de_reg.use_imm ? de_reg.imm : fwd_rs2;

    ////////////////////
    // ALU and branch resolve

    always_comb begin
        case (de_reg.alu_op)
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_pass_b: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // JAL writes the link address
    assign result = de_reg.is_jal ? de_reg.pc + 32'd4 : alu_result;

    assign operands_eq    = (op_a == fwd_rs2);
    assign branch_taken   = de_reg.is_branch && (operands_eq ^ de_reg.branch_ne);
    assign redirect_valid = de_reg.valid && (branch_taken || de_reg.is_jal);
    assign redirect_pc    = de_reg.pc + de_reg.imm;

    assign is_halt = de_reg.valid && de_reg.is_jal && (de_reg.imm == `CPU_HALT_JAL_IMM);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ew_reg <= '0;
            halted <= 1'b0;
        end else if (!run) begin
            ew_reg <= '0;
            halted <= 1'b0;
        end else begin
            ew_reg.valid <= de_reg.valid && de_reg.reg_write && (de_reg.rd != '0);
            ew_reg.rd    <= de_reg.rd;
            ew_reg.data  <= result;
            if (is_halt) halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module fetch_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    run,
    input  logic                    redirect_valid,
    input  word_t                   redirect_pc,
    input  logic                    halted,
    output logic [`CPU_IMEM_AW-1:0] imem_addr,
    input  word_t                   imem_data,
    output fetch_decode_t           fd_reg
);

    word_t pc;

    // Word address into the instruction memory
    assign imem_addr = pc[`CPU_IMEM_AW+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= '0;
            fd_reg <= '0;
        end else if (!run) begin
            pc     <= '0;
            fd_reg <= '0;
        end else if (redirect_valid) begin
            // Drop the word fetched down the wrong path
            pc     <= redirect_pc;
            fd_reg <= '0;
        end else if (halted) begin
            fd_reg <= '0;
        end else begin
            fd_reg.valid <= 1'b1;
            fd_reg.pc    <= pc;
            fd_reg.instr <= imem_data;
            pc           <= pc + 32'd4;
        end
    end

endmodule

`default_nettype wire

// ==== source/imem_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module imem_loader import isa_pkg::*, pipe_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    run,
    input  load_req_t               load_req,
    input  logic                    load_req_valid,
    output logic                    load_ack,
    input  logic [`CPU_IMEM_AW-1:0] imem_addr,
    output word_t                   imem_data
);

    typedef enum logic {
        ld_idle,
        ld_acked
    } ld_state_t;

    ld_state_t ld_state;
    word_t     mem [`CPU_IMEM_DEPTH];
    logic      do_write;

    // Accept a word only while the core is stopped
    assign do_write = (ld_state == ld_idle) && load_req_valid && !run;

    ////////////////////
    // Four-phase slave

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ld_state <= ld_idle;
        end else begin
            case (ld_state)
                ld_idle:  if (do_write) ld_state <= ld_acked;
                ld_acked: if (!load_req_valid) ld_state <= ld_idle;
                default:  ld_state <= ld_idle;
            endcase
        end
    end

    assign load_ack = (ld_state == ld_acked);

    ////////////////////
    // Instruction memory

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[load_req.addr] <= load_req.data;
        end
    end

    assign imem_data = mem[imem_addr];

endmodule

`default_nettype wire

// ==== source/isa_pkg.sv ====
`default_nettype none

`include "cpu_consts.svh"

package isa_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [4:0]           reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_t;

    // R-type layout, other formats reuse these bit positions
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } instr_fields_t;

    // funct3 codes used by decode
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

endpackage

`default_nettype wire

// ==== source/pipe_pkg.sv ====
`default_nettype none

`include "cpu_consts.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    // One word on the program load port
    typedef struct packed {
        logic [`CPU_IMEM_AW-1:0] addr;
        word_t                   data;
    } load_req_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_decode_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rd;
        logic      reg_write;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
    } decode_execute_t;

    // Execute/writeback register and retire port
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module register_file import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  retire_t   wb,
    output word_t     rega0
);

    // x0 is not stored
    word_t regs [1:`CPU_REG_COUNT-1];

    // Write data bypasses the array on a same-cycle read
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) return '0;
        if (wb.valid && wb.rd == addr) return wb.data;
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);
    assign rega0    = regs[10];

endmodule

`default_nettype wire

// ==== test/cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_checker import isa_pkg::*, pipe_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    run,
    input  logic    load_req_valid,
    input  logic    load_ack,
    input  retire_t retire,
    input  logic    halted,
    input  word_t   rega0,
    output int      error_count,
    output int      retired
);

    // Expected values filled in by tb_cpu at time 0
    reg_addr_t exp_rd [0:63];
    word_t     exp_data [0:63];
    int        exp_count;
    word_t     exp_a0;

    int   errors = 0;
    int   idx    = 0;
    logic req_q  = 1'b0;
    logic ack_q  = 1'b0;
    logic halt_q = 1'b0;

    assign error_count = errors;
    assign retired     = idx;

    // Everything is sampled mid-cycle away from the rising edge
    always @(negedge clk) begin
        ////////////////////
        // Load handshake
        if (arst_n) begin
            if (load_ack && !ack_q && !req_q) begin
                $display("Load ack rose at time %0t without a pending request", $time);
                errors++;
            end
            if (req_q && !ack_q && !load_ack) begin
                $display("Load ack did not rise one cycle after the request at time %0t",
                         $time);
                errors++;
            end
            if (!load_ack && ack_q && req_q) begin
                $display("Load ack fell at time %0t while the request was still high", $time);
                errors++;
            end
            if (!req_q && ack_q && load_ack) begin
                $display("Load ack did not fall one cycle after the request dropped at time %0t",
                         $time);
                errors++;
            end
        end

        ////////////////////
        // Retire stream in program order
        if (arst_n && run) begin
            if (retire.valid) begin
                if (idx >= exp_count) begin
                    $display("Unexpected retire of x%0d = %h at time %0t after the last one",
                             retire.rd, retire.data, $time);
                    errors++;
                end else begin
                    if (retire.rd != exp_rd[idx]) begin
                        $display("Error at time %0t: retire.rd expected %0d, got %0d",
                                 $time, exp_rd[idx], retire.rd);
                        errors++;
                    end
                    if (retire.data != exp_data[idx]) begin
                        $display("Error at time %0t: retire.data expected %h, got %h",
                                 $time, exp_data[idx], retire.data);
                        errors++;
                    end
                end
                idx++;
            end

            // Final state once the halt JAL has retired
            if (halted && !halt_q) begin
                if (idx != exp_count) begin
                    $display("Error at time %0t: retire count expected %0d, got %0d",
                             $time, exp_count, idx);
                    errors++;
                end
                if (rega0 != exp_a0) begin
                    $display("Error at time %0t: rega0 expected %h, got %h",
                             $time, exp_a0, rega0);
                    errors++;
                end
            end
        end

        req_q  = load_req_valid;
        ack_q  = load_ack;
        halt_q = halted;
    end

endmodule

`default_nettype wire

// ==== test/cpu_vectors.hex ====
// Header: program words, retire entries, expected a0, cycle budget
00000016 0000000c 0000004c 0000003c
// Program words in address order, four per line
00500093 00700113 402081b3 0011a233
123452b7 0032c333 004363b3 0023f433
00240663 06300513 06200513 00241463
00140513 00151663 00100593 00200593
00c0066f 00300693 00400693 00c50533
0030a733 0000006f
// Retire sequence as rd then data, two retires per line
00000001 00000005 00000002 00000007
00000003 fffffffe 00000004 00000001
00000005 12345000 00000006 edcbaffe
00000007 edcbafff 00000008 00000007
0000000a 00000008 0000000c 00000044
0000000a 0000004c 0000000e 00000000

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module tb_cpu import isa_pkg::*, pipe_pkg::*; ();

    localparam int VEC_WORDS       = 128;
    localparam int PROG_BASE       = 4;
    localparam int HANDSHAKE_LIMIT = 16;
    localparam int DRAIN_CYCLES    = 8;

    logic      clk;
    logic      arst_n;
    logic      run;
    load_req_t load_req;
    logic      load_req_valid;
    logic      load_ack;
    retire_t   retire;
    logic      halted;
    word_t     rega0;
    int        chk_errors;
    int        retired;

    logic [31:0] vec [0:VEC_WORDS-1];
    int          prog_len;
    int          retire_len;
    int          cycle_budget;
    int          fail_count = 0;
    logic        aborted    = 1'b0;

    cpu_top dut0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .run            (run),
        .load_req       (load_req),
        .load_req_valid (load_req_valid),
        .load_ack       (load_ack),
        .retire         (retire),
        .halted         (halted),
        .rega0          (rega0)
    );

    cpu_checker chk0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .run            (run),
        .load_req_valid (load_req_valid),
        .load_ack       (load_ack),
        .retire         (retire),
        .halted         (halted),
        .rega0          (rega0),
        .error_count    (chk_errors),
        .retired        (retired)
    );

    always #20 clk = ~clk;

    // One four-phase transfer after a random gap
    task automatic load_word(input int addr, input word_t data);
        int idle;
        int cycles;
        idle = int'($urandom % 4);
        repeat (idle) @(posedge clk);
        @(posedge clk);
        load_req.addr  <= `CPU_IMEM_AW'(addr);
        load_req.data  <= data;
        load_req_valid <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!load_ack && cycles < HANDSHAKE_LIMIT);
        if (!load_ack) begin
            $display("Timeout: load_ack never rose for program word %0d", addr);
            fail_count++;
            aborted = 1'b1;
        end else begin
            @(posedge clk);
            load_req_valid <= 1'b0;
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
            end while (load_ack && cycles < HANDSHAKE_LIMIT);
            if (load_ack) begin
                $display("Timeout: load_ack stayed high after request %0d dropped", addr);
                fail_count++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic wait_for_halt(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!halted && cycles < limit);
        if (!halted) begin
            $display("Timeout: halted did not rise within %0d cycles of run", limit);
            fail_count++;
            aborted = 1'b1;
        end
    endtask

    initial begin
        int i;
        clk            = 1'b0;
        arst_n         = 1'b0;
        run            = 1'b0;
        load_req       = '0;
        load_req_valid = 1'b0;
        void'($urandom(32'hc76f14c6));

        ////////////////////
        // Vectors and expected values
        $readmemh("test/cpu_vectors.hex", vec);
        prog_len     = int'(vec[0]);
        retire_len   = int'(vec[1]);
        cycle_budget = int'(vec[3]);
        if (prog_len < 1 || prog_len > `CPU_IMEM_DEPTH || retire_len > 64 ||
            PROG_BASE + prog_len + 2 * retire_len > VEC_WORDS) begin
            $display("Vector file header holds an impossible program or retire length");
            fail_count++;
            aborted = 1'b1;
        end else begin
            chk0.exp_count = retire_len;
            chk0.exp_a0    = vec[2];
            for (i = 0; i < retire_len; i++) begin
                chk0.exp_rd[i]   = vec[PROG_BASE + prog_len + 2 * i][4:0];
                chk0.exp_data[i] = vec[PROG_BASE + prog_len + 2 * i + 1];
            end
        end

        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        ////////////////////
        // Program load and run to halt
        for (i = 0; i < prog_len && !aborted; i++) begin
            load_word(i, vec[PROG_BASE + i]);
        end
        if (!aborted) begin
            @(posedge clk);
            run <= 1'b1;
            wait_for_halt(cycle_budget);
        end
        if (!aborted) begin
            // Idle window that would expose any retire after halt
            repeat (DRAIN_CYCLES) @(posedge clk);
        end

        $display("Summary: %0d checker errors, %0d testbench failures, %0d of %0d retired",
                 chk_errors, fail_count, retired, retire_len);
        if (chk_errors == 0 && fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
